//--- hdl/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] mem_addr_t;   // block in 10:8, word in 7:0
    typedef logic [DATA_W-1:0] mem_data_t;
    typedef logic [2:0]        block_t;
    typedef logic [7:0]        ctrl_byte_t;

    localparam logic [3:0] DEV_CODE = 4'b1010;

    // device code, block select, r/w bit
    function automatic ctrl_byte_t ctrl_byte(input mem_addr_t addr, input logic rnw);
        block_t blk;
        blk = addr[ADDR_W-1:8];
        return {DEV_CODE, blk, rnw};
    endfunction

    function automatic mem_data_t word_addr(input mem_addr_t addr);
        return addr[7:0];
    endfunction

endpackage

//--- hdl/i2c_pkg.sv
package i2c_pkg;

    typedef enum logic [1:0] {
        SEG_START,
        SEG_STOP,
        SEG_TX,     // 8 bits out, slave ack slot
        SEG_RX      // 8 bits in, master nack slot
    } seg_kind_t;

    // quarters of one bit time
    typedef enum logic [1:0] {
        PH_LOW_A,   // data changes at its end
        PH_LOW_B,
        PH_HIGH_A,  // data sampled at its end
        PH_HIGH_B
    } phase_t;

    typedef logic [3:0] bit_cnt_t;

    localparam bit_cnt_t LAST_DATA_BIT = 4'd7;
    localparam bit_cnt_t ACK_BIT       = 4'd8;

    function automatic logic scl_level(input phase_t ph);
        return (ph == PH_HIGH_A) || (ph == PH_HIGH_B);
    endfunction

endpackage

//--- hdl/scl_timer.sv
`timescale 1ns/1ps

module scl_timer #(
    parameter int QTR_CYCLES = 2
) (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               seg_go,
    input  i2c_pkg::seg_kind_t seg_kind,
    output logic               scl,
    output i2c_pkg::phase_t    phase,
    output i2c_pkg::bit_cnt_t  bit_idx,
    output logic               qtick,
    output logic               seg_done
);

    localparam int PW = (QTR_CYCLES > 1) ? $clog2(QTR_CYCLES) : 1;
    localparam logic [PW-1:0] PRESC_LAST = PW'(QTR_CYCLES - 1);

    logic              active;
    logic [PW-1:0]     presc;
    i2c_pkg::bit_cnt_t last_bit;    // 0 for start/stop, 8 for a byte
    i2c_pkg::phase_t   phase_nxt;

    assign qtick     = active && (presc == PRESC_LAST);
    assign seg_done  = qtick && (phase == i2c_pkg::PH_HIGH_B) && (bit_idx == last_bit);
    assign phase_nxt = i2c_pkg::phase_t'(phase + 2'd1);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            presc    <= '0;
            phase    <= i2c_pkg::PH_HIGH_B;   // idle bus sits in a high phase
            bit_idx  <= '0;
            last_bit <= '0;
            scl      <= 1'b1;
        end
        else if (seg_go)
        begin
            active   <= 1'b1;
            presc    <= '0;
            phase    <= i2c_pkg::PH_LOW_A;
            bit_idx  <= '0;
            scl      <= i2c_pkg::scl_level(i2c_pkg::PH_LOW_A);
            if ((seg_kind == i2c_pkg::SEG_TX) || (seg_kind == i2c_pkg::SEG_RX))
                last_bit <= i2c_pkg::ACK_BIT;
            else
                last_bit <= '0;
        end
        else if (active)
        begin
            if (!qtick)
                presc <= presc + 1'b1;
            else
            begin
                presc <= '0;
                if (seg_done)
                    active <= 1'b0;   // scl and phase hold until next seg_go
                else
                begin
                    phase <= phase_nxt;
                    scl   <= i2c_pkg::scl_level(phase_nxt);
                    if (phase == i2c_pkg::PH_HIGH_B)
                        bit_idx <= bit_idx + 4'd1;
                end
            end
        end
    end

    // a new segment only starts on an idle timer
    assert property (@(posedge CLK) disable iff (RESET)
        seg_go |-> !active);

endmodule

//--- hdl/sda_shifter.sv
`timescale 1ns/1ps

module sda_shifter (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  seg_go,
    input  i2c_pkg::seg_kind_t    seg_kind,
    input  eeprom_pkg::mem_data_t tx_byte,
    input  i2c_pkg::phase_t       phase,
    input  i2c_pkg::bit_cnt_t     bit_idx,
    input  logic                  qtick,
    input  logic                  sda_in,
    output logic                  sda_low,
    output eeprom_pkg::mem_data_t rx_byte,
    output logic                  ack_seen
);

    i2c_pkg::seg_kind_t    kind_q;
    eeprom_pkg::mem_data_t shreg;
    logic                  lo_ev;
    logic                  hi_ev;

    // end of the first low quarter and of the first high quarter
    assign lo_ev = qtick && (phase == i2c_pkg::PH_LOW_A);
    assign hi_ev = qtick && (phase == i2c_pkg::PH_HIGH_A);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            kind_q   <= i2c_pkg::SEG_STOP;
            sda_low  <= 1'b0;
            ack_seen <= 1'b0;
        end
        else if (seg_go)
        begin
            kind_q   <= seg_kind;
            ack_seen <= 1'b0;
        end
        else
        begin
            case (kind_q)
                i2c_pkg::SEG_START:
                begin
                    if (lo_ev)
                        sda_low <= 1'b0;    // line up high before scl rises
                    else if (hi_ev)
                        sda_low <= 1'b1;    // falling sda with scl high
                end
                i2c_pkg::SEG_STOP:
                begin
                    if (lo_ev)
                        sda_low <= 1'b1;
                    else if (hi_ev)
                        sda_low <= 1'b0;    // rising sda with scl high
                end
                i2c_pkg::SEG_TX:
                begin
                    if (lo_ev)
                    begin
                        if (bit_idx == i2c_pkg::ACK_BIT)
                            sda_low <= 1'b0;  // let the slave answer
                        else
                            sda_low <= !shreg[7];
                    end
                    if (hi_ev && (bit_idx == i2c_pkg::ACK_BIT))
                        ack_seen <= !sda_in;
                end
                i2c_pkg::SEG_RX:
                begin
                    if (lo_ev)
                        sda_low <= 1'b0;    // slot 8 stays released, nack
                end
                default:
                begin
                    sda_low <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (seg_go)
            shreg <= tx_byte;
        else if (lo_ev && (kind_q == i2c_pkg::SEG_TX))
            shreg <= {shreg[6:0], 1'b0};    // msb first
        if (hi_ev && (kind_q == i2c_pkg::SEG_RX) && (bit_idx <= i2c_pkg::LAST_DATA_BIT))
            rx_byte <= {rx_byte[6:0], sda_in};
    end

    // data bits only move while scl is low
    assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_low) && ((kind_q == i2c_pkg::SEG_TX) || (kind_q == i2c_pkg::SEG_RX)))
        |-> ((phase == i2c_pkg::PH_LOW_A) || (phase == i2c_pkg::PH_LOW_B)));

endmodule

//--- hdl/eeprom_seq_fsm.sv
`timescale 1ns/1ps

module eeprom_seq_fsm (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t wdata,
    input  logic                  seg_done,
    input  eeprom_pkg::mem_data_t rx_byte,
    input  logic                  ack_seen,
    output logic                  seg_go,
    output i2c_pkg::seg_kind_t    seg_kind,
    output eeprom_pkg::mem_data_t tx_byte,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output eeprom_pkg::mem_data_t rdata
);

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        WDATA,
        RESTART,
        CTRL_R,
        RDATA,
        STOP,
        FINISH
    } state_t;

    state_t                state;
    state_t                nxt;
    logic                  accept;
    logic                  tx_state;
    logic                  ack_fail;
    logic                  launch;
    logic                  stop_end;
    logic                  is_rd;
    eeprom_pkg::mem_addr_t addr_q;
    eeprom_pkg::mem_data_t wdata_q;
    i2c_pkg::seg_kind_t    launch_kind;
    eeprom_pkg::mem_data_t launch_byte;

    assign accept   = (wr || rd) && !busy;
    assign tx_state = (state == CTRL_W) || (state == ADDR) || (state == WDATA)
                      || (state == CTRL_R);
    assign ack_fail = seg_done && tx_state && !ack_seen;
    assign stop_end = (state == STOP) && seg_done;
    // every state entered from another one, except idle and finish, runs a segment
    assign launch   = (nxt != state) && (nxt != IDLE) && (nxt != FINISH);

    always_comb
    begin
        nxt = state;
        case (state)
            IDLE, FINISH:
                nxt = accept ? START : IDLE;
            START:
                if (seg_done)
                    nxt = CTRL_W;
            CTRL_W:
                if (seg_done)
                    nxt = ack_fail ? STOP : ADDR;
            ADDR:
            begin
                if (ack_fail)
                    nxt = STOP;
                else if (seg_done)
                    nxt = is_rd ? RESTART : WDATA;
            end
            WDATA:
                if (seg_done)
                    nxt = STOP;
            RESTART:
                if (seg_done)
                    nxt = CTRL_R;
            CTRL_R:
                if (seg_done)
                    nxt = ack_fail ? STOP : RDATA;
            RDATA:
                if (seg_done)
                    nxt = STOP;
            STOP:
                if (seg_done)
                    nxt = FINISH;
            default:
                nxt = IDLE;
        endcase
    end

    // segment and byte for the state being entered
    always_comb
    begin
        launch_kind = i2c_pkg::SEG_TX;
        launch_byte = eeprom_pkg::word_addr(addr_q);
        case (nxt)
            START, RESTART:
                launch_kind = i2c_pkg::SEG_START;
            STOP:
                launch_kind = i2c_pkg::SEG_STOP;
            RDATA:
                launch_kind = i2c_pkg::SEG_RX;
            CTRL_W:
                launch_byte = eeprom_pkg::ctrl_byte(addr_q, 1'b0);
            CTRL_R:
                launch_byte = eeprom_pkg::ctrl_byte(addr_q, 1'b1);
            WDATA:
                launch_byte = wdata_q;
            default:
                launch_kind = i2c_pkg::SEG_TX;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            seg_go   <= 1'b0;
            seg_kind <= i2c_pkg::SEG_STOP;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
            is_rd    <= 1'b0;
            rdata    <= '0;
        end
        else
        begin
            state  <= nxt;
            seg_go <= launch;
            done   <= stop_end;
            if (launch)
                seg_kind <= launch_kind;
            if (accept)
            begin
                busy  <= 1'b1;
                nack  <= 1'b0;
                is_rd <= !wr;   // write wins a tie
            end
            else if (stop_end)
                busy <= 1'b0;
            if (ack_fail)
                nack <= 1'b1;
            if (stop_end && is_rd && !nack)
                rdata <= rx_byte;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (launch)
            tx_byte <= launch_byte;
    end

    // the timer only finishes segments launched from a busy state
    assert property (@(posedge CLK) disable iff (RESET)
        seg_done |-> ((state != IDLE) && (state != FINISH)));

endmodule

//--- hdl/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top #(
    parameter int QTR_CYCLES = 2
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t wdata,
    output eeprom_pkg::mem_data_t rdata,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in
);

    logic                  seg_go;
    logic                  seg_done;
    logic                  qtick;
    logic                  ack_seen;
    i2c_pkg::seg_kind_t    seg_kind;
    i2c_pkg::phase_t       phase;
    i2c_pkg::bit_cnt_t     bit_idx;
    eeprom_pkg::mem_data_t tx_byte;
    eeprom_pkg::mem_data_t rx_byte;

    eeprom_seq_fsm i_eeprom_seq_fsm (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .seg_done (seg_done),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .seg_go   (seg_go),
        .seg_kind (seg_kind),
        .tx_byte  (tx_byte),
        .busy     (busy),
        .done     (done),
        .nack     (nack),
        .rdata    (rdata)
    );

    scl_timer #(
        .QTR_CYCLES (QTR_CYCLES)
    ) i_scl_timer (
        .CLK      (CLK),
        .RESET    (RESET),
        .seg_go   (seg_go),
        .seg_kind (seg_kind),
        .scl      (scl),
        .phase    (phase),
        .bit_idx  (bit_idx),
        .qtick    (qtick),
        .seg_done (seg_done)
    );

    sda_shifter i_sda_shifter (
        .CLK      (CLK),
        .RESET    (RESET),
        .seg_go   (seg_go),
        .seg_kind (seg_kind),
        .tx_byte  (tx_byte),
        .phase    (phase),
        .bit_idx  (bit_idx),
        .qtick    (qtick),
        .sda_in   (sda_in),
        .sda_low  (sda_low),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen)
    );

endmodule

//--- bench/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    localparam int ST_IDLE   = 0;
    localparam int ST_CTRL   = 1;
    localparam int ST_ADDR   = 2;
    localparam int ST_WDATA  = 3;
    localparam int ST_RDATA  = 4;
    localparam int ST_IGNORE = 5;

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;
    logic        acking;
    int          st;
    int          bit_cnt;

    initial
    begin
        logic [10:0] av;
        for (int a = 0; a < 2048; a++)
        begin
            av = 11'(a);
            mem[a] = av[7:0] ^ {5'b0, av[10:8]};
        end
        st = ST_IDLE;
        bit_cnt = 0;
        acking = 1'b0;
        sda_low = 1'b0;
        ptr = '0;
        scl_q = 1'b1;
        sda_q = 1'b1;
    end

    always @(scl or sda)
    begin
        if (scl_q && scl && sda_q && !sda)
        begin
            st = ST_CTRL;   // start or repeated start
            bit_cnt = 0;
            acking = 1'b0;
            sda_low = 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            st = ST_IDLE;
            sda_low = 1'b0;
        end
        else if (!scl_q && scl)
        begin
            if ((st == ST_CTRL || st == ST_ADDR || st == ST_WDATA) && !acking && bit_cnt < 8)
            begin
                shreg = {shreg[6:0], sda};
                bit_cnt++;
            end
            else if (st == ST_RDATA && !acking)
            begin
                if (bit_cnt < 8)
                    bit_cnt++;
                else if (sda)
                    st = ST_IGNORE;     // master nack ends the read
                else
                begin
                    ptr = {ptr[10:8], ptr[7:0] + 8'd1};
                    tx = mem[ptr];
                    bit_cnt = 0;
                end
            end
        end
        else if (scl_q && !scl)
        begin
            if (st == ST_CTRL || st == ST_ADDR || st == ST_WDATA)
            begin
                if (acking)
                begin
                    acking = 1'b0;
                    sda_low = 1'b0;
                    bit_cnt = 0;
                end
                else if (bit_cnt == 8)
                begin
                    acking = 1'b1;
                    sda_low = 1'b1;
                    if (st == ST_CTRL)
                    begin
                        if (shreg[7:4] != 4'b1010 || shreg[3:1] == 3'd7)
                        begin
                            st = ST_IGNORE;     // absent block, no ack
                            acking = 1'b0;
                            sda_low = 1'b0;
                        end
                        else
                        begin
                            ptr[10:8] = shreg[3:1];
                            if (shreg[0])
                            begin
                                st = ST_RDATA;
                                tx = mem[ptr];
                            end
                            else
                                st = ST_ADDR;
                        end
                    end
                    else if (st == ST_ADDR)
                    begin
                        ptr[7:0] = shreg;
                        st = ST_WDATA;
                    end
                    else
                    begin
                        mem[ptr] = shreg;
                        ptr = {ptr[10:8], ptr[7:0] + 8'd1};
                    end
                end
            end
            else if (st == ST_RDATA)
            begin
                if (acking)
                begin
                    acking = 1'b0;
                    bit_cnt = 0;
                    sda_low = !tx[7];
                end
                else if (bit_cnt < 8)
                    sda_low = !tx[7 - bit_cnt];
                else
                    sda_low = 1'b0;     // master answers in slot 8
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- bench/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    localparam int QTR = 2;
    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_WR_BUSY = 2;     // write with a second request while busy
    localparam int ENTRY_CYCLES = 48 * 4 * QTR;

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    logic        wr = 1'b0;
    logic        rd = 1'b0;
    logic [10:0] addr = '0;
    logic [7:0]  wdata = '0;
    logic [7:0]  rdata;
    logic        busy;
    logic        done;
    logic        nack;
    logic        scl;
    logic        sda_low;
    logic        model_sda_low;
    logic        sda;

    int          op_t [0:63];
    logic [10:0] addr_t [0:63];
    logic [7:0]  wdata_t [0:63];
    logic        nack_t [0:63];
    logic [7:0]  ref_mem [0:2047];
    logic [7:0]  exp_rdata = '0;
    int          n_ent = 0;
    int          errors = 0;
    int          checks = 0;
    int          done_count = 0;
    int          cycles = 0;
    int          limit = 1000000;
    int          seed = 32'h73de;

    assign sda = !(sda_low || model_sda_low);

    eeprom_ctrl_top #(
        .QTR_CYCLES (QTR)
    ) i_eeprom_ctrl_top (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_model i_eeprom_model (
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    always #5 CLK = ~CLK;

    always @(negedge CLK)
        if (!RESET && done)
            done_count++;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: run went past %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("** Error @%0t: %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic add_entry(input int op, input logic [10:0] a, input logic [7:0] d,
                             input logic nk);
        op_t[n_ent] = op;
        addr_t[n_ent] = a;
        wdata_t[n_ent] = d;
        nack_t[n_ent] = nk;
        n_ent++;
    endtask

    task automatic run_entry(input int i);
        int wait_cyc;
        int errs_before;
        int dones_before;
        errs_before = errors;
        while (busy)
            @(negedge CLK);
        addr = addr_t[i];
        wdata = wdata_t[i];
        wr = (op_t[i] != OP_RD);
        rd = (op_t[i] == OP_RD);
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        dones_before = done_count;
        if (op_t[i] == OP_WR_BUSY)
        begin
            @(negedge CLK);
            wr = 1'b1;      // should be dropped, busy is high
            wdata = ~wdata_t[i];
            @(negedge CLK);
            wr = 1'b0;
        end
        wait_cyc = 0;
        while (!done && wait_cyc < ENTRY_CYCLES)
        begin
            @(negedge CLK);
            wait_cyc++;
        end
        if (!done)
        begin
            $display("entry %0d: no done pulse arrived in %0d cycles", i, ENTRY_CYCLES);
            errors++;
        end
        else
        begin
            if (!nack_t[i] && op_t[i] == OP_RD)
                exp_rdata = ref_mem[addr_t[i]];
            if (!nack_t[i] && op_t[i] != OP_RD)
                ref_mem[addr_t[i]] = wdata_t[i];
            check_val("nack", 32'(nack_t[i]), 32'(nack));
            check_val("rdata", 32'(exp_rdata), 32'(rdata));
        end
        if (op_t[i] == OP_WR_BUSY)
        begin
            repeat (ENTRY_CYCLES) @(negedge CLK);   // long enough for a second transaction
            check_val("done_count", 32'(dones_before + 1), 32'(done_count));
        end
        if (op_t[i] != OP_RD && addr_t[i][10:8] != 3'd7)
            check_val("model mem", 32'(ref_mem[addr_t[i]]),
                      32'(i_eeprom_model.mem[addr_t[i]]));
        $display("entry %0d op %0d addr %h: %s", i, op_t[i], addr_t[i],
                 (errors == errs_before) ? "ok" : "bad");
    endtask

    initial
    begin
        logic [10:0] av;
        for (int a = 0; a < 2048; a++)
        begin
            av = 11'(a);
            ref_mem[a] = av[7:0] ^ {5'b0, av[10:8]};
        end
        add_entry(OP_RD, 11'h123, 8'h00, 1'b0);
        add_entry(OP_WR, 11'h123, 8'h5a, 1'b0);
        add_entry(OP_RD, 11'h123, 8'h00, 1'b0);
        add_entry(OP_WR, 11'h123, 8'ha5, 1'b0);
        add_entry(OP_RD, 11'h123, 8'h00, 1'b0);
        add_entry(OP_WR, 11'h7ab, 8'h33, 1'b1);
        add_entry(OP_RD, 11'h7ab, 8'h00, 1'b1);
        add_entry(OP_RD, 11'h0ab, 8'h00, 1'b0);
        add_entry(OP_WR_BUSY, 11'h245, 8'hc3, 1'b0);
        add_entry(OP_RD, 11'h245, 8'h00, 1'b0);
        for (int k = 0; k < 20; k++)
        begin
            av = 11'($random(seed));
            av[10:8] = 3'({$random(seed)} % 7);   // blocks 0 to 6 only
            add_entry(OP_WR, av, 8'($random(seed)), 1'b0);
            add_entry(OP_RD, av, 8'h00, 1'b0);
        end
        limit = n_ent * ENTRY_CYCLES + 100;

        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_val("busy", 32'd0, 32'(busy));
        check_val("done", 32'd0, 32'(done));
        check_val("sda_low", 32'd0, 32'(sda_low));
        check_val("scl", 32'd1, 32'(scl));

        for (int i = 0; i < n_ent; i++)
            run_entry(i);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- all.f
hdl/eeprom_pkg.sv
hdl/i2c_pkg.sv
hdl/scl_timer.sv
hdl/sda_shifter.sv
hdl/eeprom_seq_fsm.sv
hdl/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_eeprom_ctrl

out=$(./obj_dir/Vtb_eeprom_ctrl)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"
